/* frame_pkg.sv */
// beat and buffer geometry for the rx packet checker datapath
// imported by every rtl module that touches beats, slots or buffer words

package frame_pkg;

   //////////////////////////////////////////////////
   // beat geometry
   //////////////////////////////////////////////////

   // words carried by one avalon beat
   localparam int lanes = 8;

   localparam int bytes_per_word = 8;

   localparam int word_bits = bytes_per_word * 8;

   // width of the avalon empty field, counted in bytes
   localparam int empty_bits = 6;

   // selects one lane of a beat
   localparam int lane_bits = $clog2(lanes);

   //////////////////////////////////////////////////
   // packet buffer geometry
   //////////////////////////////////////////////////

   // one packet spans two full beats
   localparam int buffer_words = 2 * lanes;

   // slot index plus one spare bit, so all ones can never be a real slot
   localparam int slot_bits = $clog2(buffer_words) + 1;

   //////////////////////////////////////////////////
   // shared types
   //////////////////////////////////////////////////

   typedef logic [word_bits-1:0] word_t;

   // lane 7 is the most significant word and the first received
   typedef word_t [lanes-1:0] beat_t;

   typedef logic [slot_bits-1:0] slot_t;

   typedef logic [lanes-1:0] lane_mask_t;

   typedef logic [buffer_words-1:0] buffer_mask_t;

   // lane that goes to no buffer slot
   localparam slot_t no_slot = '1;

endpackage

/* check_pkg.sv */
// expected packet contents and counter width for the result stage
// the first received word sits in the most significant position

package check_pkg;

   import frame_pkg::*;

   // 16 words of 8 characters each, first received word first
   localparam logic [buffer_words*word_bits-1:0] expected_string = {
      "Alpha   ",
      "Bravo   ",
      "Charlie ",
      "Delta   ",
      "Echo    ",
      "Foxtrot ",
      "Golf    ",
      "Hotel   ",
      "India   ",
      "Juliett ",
      "Kilo    ",
      "Lima    ",
      "Mike    ",
      "November",
      "Oscar   ",
      "Papa    "
   };

   // width of the good packet counter
   localparam int count_bits = 32;

endpackage

/* rx_beat_decode.sv */
// first stage of the rx checker
// samples each avalon beat and marks which lanes hold payload and
// which lane closes a packet

`timescale 1ns/1ps

module rx_beat_decode
   import frame_pkg::*;
(
   input  logic                  rx_clk,
   input  logic                  rx_arst_local,
   input  beat_t                 avl_data_in,
   input  logic                  avl_valid_in,
   input  logic                  avl_eop_in,
   input  logic [empty_bits-1:0] avl_empty_in,
   output beat_t                 beat_data,
   output lane_mask_t            payload_lanes,
   output lane_mask_t            delimiter_lanes
);

   logic       full_beat;
   lane_mask_t payload_d;
   lane_mask_t delimiter_d;

   //////////////////////////////////////////////////
   // beat classification
   //////////////////////////////////////////////////

   // only a completely filled beat carries payload
   always_comb begin
      full_beat = 1'b0;
      if (avl_valid_in) begin
         if (avl_eop_in) begin
            // trailing bytes of the last word may be empty
            full_beat = (avl_empty_in < empty_bits'(bytes_per_word));
         end else begin
            full_beat = (avl_empty_in == '0);
         end
      end
   end

   always_comb begin
      payload_d = {lanes{full_beat}};
      delimiter_d = '0;
      // lane 0 is the last word in time, so the packet closes there
      delimiter_d[0] = avl_valid_in & avl_eop_in;
   end

   //////////////////////////////////////////////////
   // input register
   //////////////////////////////////////////////////

   always_ff @(posedge rx_clk or posedge rx_arst_local) begin
      if (rx_arst_local) begin
         payload_lanes   <= '0;
         delimiter_lanes <= '0;
      end else begin
         payload_lanes   <= payload_d;
         delimiter_lanes <= delimiter_d;
      end
   end

   // beat words travel beside the masks
   always_ff @(posedge rx_clk) begin
      beat_data <= avl_data_in;
   end

endmodule

/* rx_slot_assign.sv */
// gives each payload lane a slot in the packet buffer
// the slot counter runs through lanes 7..0 and carries over between beats

`timescale 1ns/1ps

module rx_slot_assign
   import frame_pkg::*;
(
   input  logic                rx_clk,
   input  logic                rx_arst_local,
   input  beat_t               beat_data,
   input  lane_mask_t          payload_lanes,
   input  lane_mask_t          delimiter_lanes,
   output slot_t [lanes-1:0]   lane_slots,
   output beat_t               lane_data
);

   // slot index without the spare bit
   logic [slot_bits-2:0] count_q;
   logic [slot_bits-2:0] run;
   slot_t [lanes-1:0]    slots_d;

   //////////////////////////////////////////////////
   // counter chain in time order
   //////////////////////////////////////////////////

   always_comb begin
      run = count_q;
      for (int lane = lanes - 1; lane >= 0; lane--) begin
         if (payload_lanes[lane]) begin
            slots_d[lane] = {1'b0, run};
         end else begin
            slots_d[lane] = no_slot;
         end

         // the delimiter word still takes its slot, the next packet restarts at 0
         if (delimiter_lanes[lane]) begin
            run = '0;
         end else if (payload_lanes[lane]) begin
            run = run + 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // registers
   //////////////////////////////////////////////////

   always_ff @(posedge rx_clk or posedge rx_arst_local) begin
      if (rx_arst_local) begin
         count_q    <= '0;
         lane_slots <= {lanes{no_slot}};
      end else begin
         count_q    <= run;
         lane_slots <= slots_d;
      end
   end

   // data stays aligned with its slot numbers
   always_ff @(posedge rx_clk) begin
      lane_data <= beat_data;
   end

endmodule

/* rx_buffer_fill.sv */
// moves lane words into the 16 word packet buffer
// three stages from slot numbers to buffer: select decode, select encode, write
// outputs are in first received order, slot 0 in the top word

`timescale 1ns/1ps

module rx_buffer_fill
   import frame_pkg::*;
(
   input  logic                       rx_clk,
   input  logic                       rx_arst_local,
   input  slot_t [lanes-1:0]          lane_slots,
   input  beat_t                      lane_data,
   output word_t [buffer_words-1:0]   buffer_data,
   output buffer_mask_t               slot_fresh
);

   lane_mask_t [buffer_words-1:0]     hit_q;
   logic [buffer_words-1:0][lane_bits-1:0] sel_d;
   logic [buffer_words-1:0][lane_bits-1:0] sel_q;
   buffer_mask_t                      src_fresh_q;
   buffer_mask_t                      written_q;
   beat_t                             data_d1;
   beat_t                             data_d2;
   // slot-ordered buffer, slot 0 at index 0
   word_t [buffer_words-1:0]          buffer_q;

   //////////////////////////////////////////////////
   // select array
   //////////////////////////////////////////////////

   always_ff @(posedge rx_clk or posedge rx_arst_local) begin
      if (rx_arst_local) begin
         hit_q       <= '0;
         sel_q       <= '0;
         src_fresh_q <= '0;
         written_q   <= '0;
      end else begin
         // which lanes target each slot
         for (int s = 0; s < buffer_words; s++) begin
            for (int lane = 0; lane < lanes; lane++) begin
               hit_q[s][lane] <= (lane_slots[lane] == slot_t'(s));
            end
         end
         sel_q       <= sel_d;
         for (int s = 0; s < buffer_words; s++) begin
            src_fresh_q[s] <= |hit_q[s];
         end
         written_q   <= src_fresh_q;
      end
   end

   // at most one lane hits a slot per beat, so or-ing lane numbers encodes it
   always_comb begin
      for (int s = 0; s < buffer_words; s++) begin
         sel_d[s] = '0;
         for (int lane = 0; lane < lanes; lane++) begin
            if (hit_q[s][lane]) begin
               sel_d[s] = sel_d[s] | lane_bits'(lane);
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // data delay and buffer write
   //////////////////////////////////////////////////

   always_ff @(posedge rx_clk) begin
      data_d1 <= lane_data;
      data_d2 <= data_d1;
      for (int s = 0; s < buffer_words; s++) begin
         if (src_fresh_q[s]) begin
            buffer_q[s] <= data_d2[sel_q[s]];
         end
      end
   end

   // flip so the first received word is most significant
   always_comb begin
      for (int i = 0; i < buffer_words; i++) begin
         buffer_data[i] = buffer_q[buffer_words-1-i];
         slot_fresh[i]  = written_q[buffer_words-1-i];
      end
   end

endmodule

/* rx_packet_accept.sv */
// compares the packet buffer with the expected string and counts good packets
// a verdict is given each time all 16 slots have been written

`timescale 1ns/1ps

module rx_packet_accept
   import frame_pkg::*;
   import check_pkg::*;
(
   input  logic                      rx_clk,
   input  logic                      rx_arst_local,
   input  word_t [buffer_words-1:0]  buffer_data,
   input  buffer_mask_t              slot_fresh,
   output logic                      rx_packet_accept,
   output logic [count_bits-1:0]     rx_counter
);

   buffer_mask_t fresh_q;
   buffer_mask_t compare_q;
   buffer_mask_t written_q;
   buffer_mask_t match_q;

   //////////////////////////////////////////////////
   // per slot compare
   //////////////////////////////////////////////////

   always_ff @(posedge rx_clk or posedge rx_arst_local) begin
      if (rx_arst_local) begin
         fresh_q   <= '0;
         compare_q <= '0;
      end else begin
         fresh_q <= slot_fresh;
         for (int i = 0; i < buffer_words; i++) begin
            compare_q[i] <= (buffer_data[i] == expected_string[i*word_bits +: word_bits]);
         end
      end
   end

   //////////////////////////////////////////////////
   // written and match flags, verdict
   //////////////////////////////////////////////////

   always_ff @(posedge rx_clk or posedge rx_arst_local) begin
      if (rx_arst_local) begin
         written_q        <= '0;
         match_q          <= '0;
         rx_packet_accept <= 1'b0;
         rx_counter       <= '0;
      end else begin
         // a match flag follows the latest write to its slot
         match_q <= (fresh_q & compare_q) | (~fresh_q & match_q);

         if (&written_q) begin
            rx_packet_accept <= &match_q;
            // keep slots of the next packet that land in the same cycle
            written_q        <= fresh_q;
         end else begin
            rx_packet_accept <= 1'b0;
            written_q        <= written_q | fresh_q;
         end

         if (rx_packet_accept) begin
            rx_counter <= rx_counter + 1'b1;
         end
      end
   end

endmodule

/* rx_packet_checker.sv */
// top level of the rx packet checker
// avalon beats in, good packet pulse and running count out

`timescale 1ns/1ps

module rx_packet_checker
   import frame_pkg::*;
   import check_pkg::*;
(
   input  logic                  rx_clk,
   input  logic                  rx_arst_local,
   input  beat_t                 avl_data_in,
   input  logic                  avl_valid_in,
   input  logic                  avl_eop_in,
   input  logic [empty_bits-1:0] avl_empty_in,
   output logic                  rx_packet_accept,
   output logic [count_bits-1:0] rx_counter
);

   beat_t                    beat_data;
   lane_mask_t               payload_lanes;
   lane_mask_t               delimiter_lanes;
   slot_t [lanes-1:0]        lane_slots;
   beat_t                    lane_data;
   word_t [buffer_words-1:0] buffer_data;
   buffer_mask_t             slot_fresh;

   rx_beat_decode u_beat_decode (
      .rx_clk          (rx_clk),
      .rx_arst_local   (rx_arst_local),
      .avl_data_in     (avl_data_in),
      .avl_valid_in    (avl_valid_in),
      .avl_eop_in      (avl_eop_in),
      .avl_empty_in    (avl_empty_in),
      .beat_data       (beat_data),
      .payload_lanes   (payload_lanes),
      .delimiter_lanes (delimiter_lanes)
   );

   rx_slot_assign u_slot_assign (
      .rx_clk          (rx_clk),
      .rx_arst_local   (rx_arst_local),
      .beat_data       (beat_data),
      .payload_lanes   (payload_lanes),
      .delimiter_lanes (delimiter_lanes),
      .lane_slots      (lane_slots),
      .lane_data       (lane_data)
   );

   rx_buffer_fill u_buffer_fill (
      .rx_clk        (rx_clk),
      .rx_arst_local (rx_arst_local),
      .lane_slots    (lane_slots),
      .lane_data     (lane_data),
      .buffer_data   (buffer_data),
      .slot_fresh    (slot_fresh)
   );

   rx_packet_accept u_packet_accept (
      .rx_clk           (rx_clk),
      .rx_arst_local    (rx_arst_local),
      .buffer_data      (buffer_data),
      .slot_fresh       (slot_fresh),
      .rx_packet_accept (rx_packet_accept),
      .rx_counter       (rx_counter)
   );

endmodule

/* tb_clock_gen.sv */
// clock and reset source for the rx packet checker testbench
// 20 ns rx_clk, reset held high for the first 16 cycles

`timescale 1ns/1ps

module tb_clock_gen (
   output logic rx_clk,
   output logic rx_arst_local
);

   localparam int half_period  = 10;
   localparam int reset_cycles = 16;

   initial begin
      rx_clk = 1'b0;
      forever #(half_period) rx_clk = ~rx_clk;
   end

   // reset drops on a falling edge, well away from the sampling edge
   initial begin
      rx_arst_local = 1'b1;
      repeat (reset_cycles) @(negedge rx_clk);
      rx_arst_local = 1'b0;
   end

endmodule

/* tb_rx_packet_checker.sv */
// testbench for the rx packet checker
// sends good, corrupted and padded packets and checks accept pulses and the count

`timescale 1ns/1ps

module tb_rx_packet_checker
   import frame_pkg::*;
   import check_pkg::*;
();

   localparam logic [31:0] seed = 32'h19b17b0b;
   localparam int wait_limit     = 100;
   localparam int quiet_cycles   = 12;
   localparam int accept_latency = 7;

   typedef logic [buffer_words*word_bits-1:0] packet_t;

   logic                  rx_clk;
   logic                  rx_arst_local;
   beat_t                 avl_data_in;
   logic                  avl_valid_in;
   logic                  avl_eop_in;
   logic [empty_bits-1:0] avl_empty_in;
   logic                  rx_packet_accept;
   logic [count_bits-1:0] rx_counter;

   logic [31:0] rng_state;
   int          cycle = 0;
   int          pulses_seen = 0;
   int          expected_good = 0;
   int          check_errors = 0;
   int          timeouts = 0;
   int          last_eop_edge = 0;
   logic        accept_prev = 1'b0;

   tb_clock_gen clock_gen (
      .rx_clk        (rx_clk),
      .rx_arst_local (rx_arst_local)
   );

   rx_packet_checker UUT (
      .rx_clk           (rx_clk),
      .rx_arst_local    (rx_arst_local),
      .avl_data_in      (avl_data_in),
      .avl_valid_in     (avl_valid_in),
      .avl_eop_in       (avl_eop_in),
      .avl_empty_in     (avl_empty_in),
      .rx_packet_accept (rx_packet_accept),
      .rx_counter       (rx_counter)
   );

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////

   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic void report_error(string what, longint got, longint want);
      check_errors++;
      $display("ERR time %0t: %s, got %0d, expected %0d", $time, what, got, want);
   endfunction

   task automatic note_timeout(string what);
      timeouts++;
      $display("timeout: %s did not happen within %0d cycles", what, wait_limit);
   endtask

   task automatic drive_beat(beat_t data, logic valid, logic eop, logic [empty_bits-1:0] empty);
      @(negedge rx_clk);
      avl_data_in  = data;
      avl_valid_in = valid;
      avl_eop_in   = eop;
      avl_empty_in = empty;
   endtask

   task automatic drive_idle();
      drive_beat('0, 1'b0, 1'b0, '0);
   endtask

   // valid but partly empty beat without eop, carries no payload
   task automatic drive_junk();
      logic [31:0] r;
      r = next_random();
      drive_beat({16{r}}, 1'b1, 1'b0, empty_bits'(r % 63 + 1));
   endtask

   // bad_word below 0 sends a clean packet; filler 1 puts an idle and
   // filler 2 a junk beat between the two halves
   task automatic send_packet(int bad_word, logic [empty_bits-1:0] eop_empty, int filler);
      packet_t pkt;
      word_t   flip;
      pkt = expected_string;
      if (bad_word >= 0) begin
         flip[63:32] = next_random();
         flip[31:0]  = next_random() | 32'h1;
         pkt[bad_word*word_bits +: word_bits] = pkt[bad_word*word_bits +: word_bits] ^ flip;
      end
      drive_beat(pkt[buffer_words*word_bits-1 -: lanes*word_bits], 1'b1, 1'b0, '0);
      if (filler == 1) begin
         drive_idle();
      end else if (filler == 2) begin
         drive_junk();
      end
      drive_beat(pkt[lanes*word_bits-1:0], 1'b1, 1'b1, eop_empty);
      last_eop_edge = cycle + 1;
      if (bad_word < 0) begin
         expected_good++;
      end
   endtask

   task automatic wait_for_pulses(int target);
      int n;
      n = 0;
      while (pulses_seen < target && n < wait_limit) begin
         @(negedge rx_clk);
         n++;
      end
      if (pulses_seen < target) begin
         note_timeout("the expected accept pulses");
      end
   endtask

   // lets the pipeline drain, then compares against the model count
   task automatic check_count();
      repeat (quiet_cycles) @(negedge rx_clk);
      assert (pulses_seen == expected_good)
      else report_error("accept pulse count", pulses_seen, expected_good);
      assert (rx_counter == count_bits'(expected_good))
      else report_error("rx_counter", rx_counter, expected_good);
   endtask

   //////////////////////////////////////////////////
   // output monitor
   //////////////////////////////////////////////////

   always @(posedge rx_clk) begin
      cycle <= cycle + 1;
   end

   // outputs change on the rising edge, so they are sampled on the falling one
   always @(negedge rx_clk) begin
      if (rx_arst_local) begin
         assert (rx_counter == '0 && !rx_packet_accept)
         else report_error("outputs not idle in reset", rx_counter, 0);
      end else begin
         assert (rx_counter == count_bits'(pulses_seen))
         else report_error("rx_counter against seen pulses", rx_counter, pulses_seen);
         assert (!(rx_packet_accept && accept_prev))
         else report_error("accept pulse width in cycles", 2, 1);
         if (rx_packet_accept) begin
            pulses_seen <= pulses_seen + 1;
         end
      end
      accept_prev = rx_packet_accept;
   end

   //////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////

   initial begin
      int          n;
      logic [31:0] r;
      rng_state    = seed;
      avl_data_in  = '0;
      avl_valid_in = 1'b0;
      avl_eop_in   = 1'b0;
      avl_empty_in = '0;

      // reset is only looked at from the first falling edge on
      n = 0;
      do begin
         @(negedge rx_clk);
         n++;
      end while (rx_arst_local && n < wait_limit);
      if (rx_arst_local) begin
         note_timeout("reset release");
      end
      check_count();

      // isolated packet, accept follows the eop sampling edge by a fixed count
      send_packet(-1, '0, 0);
      drive_idle();
      n = 0;
      while (!rx_packet_accept && n < wait_limit) begin
         @(negedge rx_clk);
         n++;
      end
      if (!rx_packet_accept) begin
         note_timeout("the isolated accept pulse");
      end else begin
         assert (cycle - last_eop_edge == accept_latency)
         else report_error("accept latency in cycles", cycle - last_eop_edge, accept_latency);
      end
      check_count();

      repeat (6) send_packet(-1, '0, 0);
      drive_idle();
      wait_for_pulses(expected_good);
      check_count();

      // corrupted packet alone, then corrupted and good back to back
      send_packet(int'(next_random() % 16), '0, 0);
      drive_idle();
      check_count();
      send_packet(-1, '0, 0);
      send_packet(int'(next_random() % 16), '0, 0);
      send_packet(-1, '0, 0);
      drive_idle();
      wait_for_pulses(expected_good);
      check_count();

      // random gaps, junk beats, corruption and eop empty values
      for (int i = 0; i < 40; i++) begin
         r = next_random();
         repeat (r[1:0]) drive_idle();
         if (r[2]) begin
            drive_junk();
         end
         send_packet((r[4:3] == 2'b00) ? int'(r[11:8]) : -1, empty_bits'(r[14:12]),
                     int'(r[17:16]) % 3);
      end
      drive_idle();
      wait_for_pulses(expected_good);
      check_count();

      for (int e = 1; e < bytes_per_word; e++) begin
         send_packet(-1, empty_bits'(e), 0);
      end
      drive_idle();
      wait_for_pulses(expected_good);
      check_count();

      $display("checks failed: %0d, timeouts: %0d, accept pulses: %0d of %0d expected",
               check_errors, timeouts, pulses_seen, expected_good);
      if (check_errors == 0 && timeouts == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* sources.f */
frame_pkg.sv
check_pkg.sv
rx_beat_decode.sv
rx_slot_assign.sv
rx_buffer_fill.sv
rx_packet_accept.sv
rx_packet_checker.sv
tb_clock_gen.sv
tb_rx_packet_checker.sv

/* run_sim.sh */
#!/bin/sh
# builds the rx packet checker testbench with verilator and runs it
# the run fails when the log holds the fail message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_rx_packet_checker -f sources.f

./obj_dir/Vtb_rx_packet_checker > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
   exit 1
fi
exit 0
